// File: logic/bpu_pkg.sv
/*
  Shared widths, table sizes and encodings for the branch prediction unit.
  Addresses are word addresses, the byte address with its two low bits dropped.
  Fetch carries the update token back to writeback unopened.
*/
`default_nettype none

package bpu_pkg;

   // Address and fetch geometry
   localparam int addr_w      = 30;
   localparam int fetch_slots = 2;

   // Table sizes
   localparam int pht_idx_w = 8;
   localparam int btb_idx_w = 6;
   localparam int btb_tag_w = addr_w - btb_idx_w;

   typedef logic [addr_w-1:0]    word_t;
   typedef logic [pht_idx_w-1:0] pht_idx_t;
   typedef logic [btb_idx_w-1:0] btb_idx_t;
   typedef logic [btb_tag_w-1:0] btb_tag_t;

   // 2-bit saturating counter, top bit set means predict taken
   typedef logic [1:0] ctr_t;

   localparam ctr_t ctr_snt   = 2'b00;
   localparam ctr_t ctr_wnt   = 2'b01;
   localparam ctr_t ctr_wt    = 2'b10;
   localparam ctr_t ctr_st    = 2'b11;
   localparam ctr_t ctr_reset = ctr_wnt;

   // Target buffer entry
   typedef struct packed {
      logic     valid;
      logic     is_cond;
      btb_tag_t tag;
      word_t    target;
   } btb_entry_t;

   // Update token, counter as read in the upper bits, table index below
   localparam int upd_w = $bits(ctr_t) + pht_idx_w;

   typedef struct packed {
      ctr_t     ctr;
      pht_idx_t idx;
   } upd_t;

endpackage

`default_nettype wire

// File: logic/bpu_table.sv
/*
  Register-array table with one write port and several registered read ports.
  Read data appears one edge after its enable and holds while the enable is low.
  A read at the same edge as a write returns the old entry.
  Reset loads reset_value into every entry and clears the read registers.
*/
`timescale 1ns/1ps
`default_nettype none

module bpu_table
#(
   parameter type    entry_t     = logic [7:0],
   parameter int     depth_log2  = 4,
   parameter int     reads       = 1,
   parameter entry_t reset_value = entry_t'(0)
)
(
   input  wire                                 clk,
   input  wire                                 rst_n,
   input  wire  [reads-1:0]                    re,
   input  wire  [reads-1:0][depth_log2-1:0]    raddr,
   output entry_t [reads-1:0]                  rdata,
   input  wire                                 we,
   input  wire  [depth_log2-1:0]               waddr,
   input  entry_t                              wdata
);

   localparam int depth = 1 << depth_log2;

   entry_t mem [depth];

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < depth; i++)
            mem[i] <= reset_value;
      end
      else if (we)
         mem[waddr] <= wdata;
   end

   // Each read port holds its data until its own enable
   always_ff @(posedge clk)
   begin
      for (int r = 0; r < reads; r++)
      begin
         if (!rst_n)
            rdata[r] <= entry_t'(0);
         else if (re[r])
            rdata[r] <= mem[raddr[r]];
      end
   end

endmodule

`default_nettype wire

// File: logic/bpu_pht.sv
/*
  Gshare pattern history table of 2-bit saturating counters.
  Index is the low pc bits XORed with the global history.
  Only conditional writebacks train a counter or shift the history.
  A lookup at the same edge as a writeback sees the old history and counters.
*/
`timescale 1ns/1ps
`default_nettype none

module bpu_pht
(
   input  wire                                               clk,
   input  wire                                               rst_n,
   input  wire                                               re,
   input  bpu_pkg::word_t   [bpu_pkg::fetch_slots-1:0]       pc,
   output bpu_pkg::ctr_t    [bpu_pkg::fetch_slots-1:0]       pht_ctr,
   output bpu_pkg::pht_idx_t [bpu_pkg::fetch_slots-1:0]      pht_idx,
   input  wire                                               wb_valid,
   input  wire                                               wb_is_cond,
   input  wire                                               wb_taken,
   input  bpu_pkg::ctr_t                                     wb_ctr,
   input  bpu_pkg::pht_idx_t                                 wb_idx
);

   import bpu_pkg::*;

   pht_idx_t                    ghist;
   pht_idx_t [fetch_slots-1:0]  hash_idx;
   logic                        wb_we;
   ctr_t                        wb_din;

   // Hash each slot's address with the current history
   always_comb
   begin
      for (int s = 0; s < fetch_slots; s++)
         hash_idx[s] = pc[s][pht_idx_w-1:0] ^ ghist;
   end

   // Index travels with the counter so the token names the entry read
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         pht_idx <= '0;
      else if (re)
         pht_idx <= hash_idx;
   end

   assign wb_we = wb_valid & wb_is_cond;

   // Saturating step of the counter carried back in the token
   always_comb
   begin
      case (wb_ctr)
         ctr_snt: wb_din = wb_taken ? ctr_wnt : ctr_snt;
         ctr_wnt: wb_din = wb_taken ? ctr_wt  : ctr_snt;
         ctr_wt:  wb_din = wb_taken ? ctr_st  : ctr_wnt;
         default: wb_din = wb_taken ? ctr_st  : ctr_wt;
      endcase
   end

   // Newest outcome enters at the low end
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         ghist <= '0;
      else if (wb_we)
         ghist <= {ghist[pht_idx_w-2:0], wb_taken};
   end

   bpu_table
   #(
      .entry_t     (ctr_t),
      .depth_log2  (pht_idx_w),
      .reads       (fetch_slots),
      .reset_value (ctr_reset)
   )
   ctr_table
   (
      .clk   (clk),
      .rst_n (rst_n),
      .re    ({fetch_slots{re}}),
      .raddr (hash_idx),
      .rdata (pht_ctr),
      .we    (wb_we),
      .waddr (wb_idx),
      .wdata (wb_din)
   );

endmodule

`default_nettype wire

// File: logic/bpu_btb.sv
/*
  Direct-mapped, tagged branch target buffer.
  Jumps and taken conditional branches are installed, overwriting the old entry.
  Not-taken conditional branches leave the buffer untouched.
  The stored kind bit lets the selector gate conditional entries on the counter.
*/
`timescale 1ns/1ps
`default_nettype none

module bpu_btb
(
   input  wire                                           clk,
   input  wire                                           rst_n,
   input  wire                                           re,
   input  bpu_pkg::word_t [bpu_pkg::fetch_slots-1:0]     pc,
   output logic           [bpu_pkg::fetch_slots-1:0]     btb_hit,
   output logic           [bpu_pkg::fetch_slots-1:0]     btb_is_cond,
   output bpu_pkg::word_t [bpu_pkg::fetch_slots-1:0]     btb_target,
   input  wire                                           wb_valid,
   input  wire                                           wb_is_cond,
   input  wire                                           wb_is_jump,
   input  wire                                           wb_taken,
   input  bpu_pkg::word_t                                wb_pc,
   input  bpu_pkg::word_t                                wb_target
);

   import bpu_pkg::*;

   btb_idx_t   [fetch_slots-1:0] rd_idx;
   btb_tag_t   [fetch_slots-1:0] tag_q;
   btb_entry_t [fetch_slots-1:0] rd_entry;
   logic                         wb_we;
   btb_entry_t                   wb_entry;

   always_comb
   begin
      for (int s = 0; s < fetch_slots; s++)
         rd_idx[s] = pc[s][btb_idx_w-1:0];
   end

   // Tag is compared one cycle later against the entry read out
   always_ff @(posedge clk)
   begin
      for (int s = 0; s < fetch_slots; s++)
      begin
         if (!rst_n)
            tag_q[s] <= '0;
         else if (re)
            tag_q[s] <= pc[s][addr_w-1:btb_idx_w];
      end
   end

   always_comb
   begin
      for (int s = 0; s < fetch_slots; s++)
      begin
         btb_hit[s]     = rd_entry[s].valid && (rd_entry[s].tag == tag_q[s]);
         btb_is_cond[s] = rd_entry[s].is_cond;
         btb_target[s]  = rd_entry[s].target;
      end
   end

   assign wb_we = wb_valid & (wb_is_jump | (wb_is_cond & wb_taken));

   always_comb
   begin
      wb_entry.valid   = 1'b1;
      wb_entry.is_cond = wb_is_cond;
      wb_entry.tag     = wb_pc[addr_w-1:btb_idx_w];
      wb_entry.target  = wb_target;
   end

   bpu_table
   #(
      .entry_t     (btb_entry_t),
      .depth_log2  (btb_idx_w),
      .reads       (fetch_slots),
      .reset_value (btb_entry_t'(0))
   )
   entry_table
   (
      .clk   (clk),
      .rst_n (rst_n),
      .re    ({fetch_slots{re}}),
      .raddr (rd_idx),
      .rdata (rd_entry),
      .we    (wb_we),
      .waddr (wb_pc[btb_idx_w-1:0]),
      .wdata (wb_entry)
   );

endmodule

`default_nettype wire

// File: logic/bpu_npc_sel.sv
/*
  Per-slot next address choice and update token packing.
  Registers pc plus one under re, aligned with the table reads.
  After reset the fall-through address is word one, so npc starts at 0 + 1.
*/
`timescale 1ns/1ps
`default_nettype none

module bpu_npc_sel
(
   input  wire                                             clk,
   input  wire                                             rst_n,
   input  wire                                             re,
   input  bpu_pkg::word_t    [bpu_pkg::fetch_slots-1:0]    pc,
   input  bpu_pkg::ctr_t     [bpu_pkg::fetch_slots-1:0]    pht_ctr,
   input  bpu_pkg::pht_idx_t [bpu_pkg::fetch_slots-1:0]    pht_idx,
   input  wire               [bpu_pkg::fetch_slots-1:0]    btb_hit,
   input  wire               [bpu_pkg::fetch_slots-1:0]    btb_is_cond,
   input  bpu_pkg::word_t    [bpu_pkg::fetch_slots-1:0]    btb_target,
   output bpu_pkg::word_t    [bpu_pkg::fetch_slots-1:0]    npc,
   output bpu_pkg::upd_t     [bpu_pkg::fetch_slots-1:0]    upd
);

   import bpu_pkg::*;

   word_t [fetch_slots-1:0] pc_p1_q;
   logic  [fetch_slots-1:0] redirect;

   always_ff @(posedge clk)
   begin
      for (int s = 0; s < fetch_slots; s++)
      begin
         if (!rst_n)
            pc_p1_q[s] <= word_t'(1);
         else if (re)
            pc_p1_q[s] <= pc[s] + word_t'(1);
      end
   end

   always_comb
   begin
      for (int s = 0; s < fetch_slots; s++)
      begin
         // Jumps always redirect, conditionals only when predicted taken
         redirect[s] = btb_hit[s] & (~btb_is_cond[s] | pht_ctr[s][1]);
         npc[s]      = redirect[s] ? btb_target[s] : pc_p1_q[s];

         upd[s].ctr = pht_ctr[s];
         upd[s].idx = pht_idx[s];
      end
   end

endmodule

`default_nettype wire

// File: logic/bpu.sv
/*
  Branch prediction unit top level for a multi-slot fetch stage.
  Lookup latency is one cycle. Holding re low repeats the last result.
  One resolved branch per cycle on the writeback port, no back-pressure.
*/
`timescale 1ns/1ps
`default_nettype none

module bpu
(
   input  wire                                           clk,
   input  wire                                           rst_n,
   input  wire                                           re,
   input  bpu_pkg::word_t [bpu_pkg::fetch_slots-1:0]     pc,
   output bpu_pkg::word_t [bpu_pkg::fetch_slots-1:0]     npc,
   output bpu_pkg::upd_t  [bpu_pkg::fetch_slots-1:0]     upd,
   input  wire                                           wb_valid,
   input  wire                                           wb_is_cond,
   input  wire                                           wb_is_jump,
   input  wire                                           wb_taken,
   input  bpu_pkg::word_t                                wb_pc,
   input  bpu_pkg::word_t                                wb_target,
   input  bpu_pkg::upd_t                                 wb_upd
);

   import bpu_pkg::*;

   ctr_t                         wb_ctr;
   pht_idx_t                     wb_idx;
   ctr_t     [fetch_slots-1:0]   pht_ctr;
   pht_idx_t [fetch_slots-1:0]   pht_idx;
   logic     [fetch_slots-1:0]   btb_hit;
   logic     [fetch_slots-1:0]   btb_is_cond;
   word_t    [fetch_slots-1:0]   btb_target;

   // Token comes back from fetch as it was handed out
   assign wb_ctr = wb_upd.ctr;
   assign wb_idx = wb_upd.idx;

   bpu_pht pht_inst
   (
      .clk        (clk),
      .rst_n      (rst_n),
      .re         (re),
      .pc         (pc),
      .pht_ctr    (pht_ctr),
      .pht_idx    (pht_idx),
      .wb_valid   (wb_valid),
      .wb_is_cond (wb_is_cond),
      .wb_taken   (wb_taken),
      .wb_ctr     (wb_ctr),
      .wb_idx     (wb_idx)
   );

   bpu_btb btb_inst
   (
      .clk         (clk),
      .rst_n       (rst_n),
      .re          (re),
      .pc          (pc),
      .btb_hit     (btb_hit),
      .btb_is_cond (btb_is_cond),
      .btb_target  (btb_target),
      .wb_valid    (wb_valid),
      .wb_is_cond  (wb_is_cond),
      .wb_is_jump  (wb_is_jump),
      .wb_taken    (wb_taken),
      .wb_pc       (wb_pc),
      .wb_target   (wb_target)
   );

   bpu_npc_sel npc_sel_inst
   (
      .clk         (clk),
      .rst_n       (rst_n),
      .re          (re),
      .pc          (pc),
      .pht_ctr     (pht_ctr),
      .pht_idx     (pht_idx),
      .btb_hit     (btb_hit),
      .btb_is_cond (btb_is_cond),
      .btb_target  (btb_target),
      .npc         (npc),
      .upd         (upd)
   );

endmodule

`default_nettype wire

// File: tests/bpu_chk.sv
/*
  Assertions bound to the branch prediction unit top level.
  Keeps its own copy of the registered pc to know the fall-through address.
*/
`timescale 1ns/1ps
`default_nettype none

module bpu_chk
(
   input wire                                          clk,
   input wire                                          rst_n,
   input wire                                          re,
   input bpu_pkg::word_t [bpu_pkg::fetch_slots-1:0]    pc,
   input bpu_pkg::word_t [bpu_pkg::fetch_slots-1:0]    npc,
   input bpu_pkg::word_t [bpu_pkg::fetch_slots-1:0]    btb_target
);

   import bpu_pkg::*;

   word_t [fetch_slots-1:0] pc_q;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         pc_q <= '0;
      else if (re)
         pc_q <= pc;
   end

   // Outputs repeat while fetch stalls
   npc_hold: assert property (@(posedge clk) disable iff (!rst_n) !re |=> $stable(npc))
      else $error("npc changed after a cycle with re low");

   for (genvar s = 0; s < fetch_slots; s++)
   begin : g_slot
      npc_legal: assert property (@(posedge clk) disable iff (!rst_n)
         !$isunknown(npc[s]) && (npc[s] == btb_target[s] || npc[s] == pc_q[s] + word_t'(1)))
         else $error("npc of slot %0d is neither a target nor pc plus one", s);
   end

endmodule

bind bpu bpu_chk bpu_chk_inst
(
   .clk        (clk),
   .rst_n      (rst_n),
   .re         (re),
   .pc         (pc),
   .npc        (npc),
   .btb_target (btb_target)
);

`default_nettype wire

// File: tests/bpu_tb.sv
/*
  Testbench for the branch prediction unit, driven from tests/bpu_vectors.txt.
  Must run from the project root so the vector file path resolves.
  Inputs change on falling edges, outputs are compared on the next falling edge.
*/
`timescale 1ns/1ps
`default_nettype none

module bpu_tb;

   import bpu_pkg::*;

   localparam int clk_period = 40;

   logic                     clk;
   logic                     rst_n;
   logic                     re;
   word_t [fetch_slots-1:0]  pc;
   word_t [fetch_slots-1:0]  npc;
   upd_t  [fetch_slots-1:0]  upd;
   logic                     wb_valid;
   logic                     wb_is_cond;
   logic                     wb_is_jump;
   logic                     wb_taken;
   word_t                    wb_pc;
   word_t                    wb_target;
   upd_t                     wb_upd;

   int n_checks;
   int n_errs;
   int n_tests;
   int test_errs;

   bpu bpu_inst
   (
      .clk        (clk),
      .rst_n      (rst_n),
      .re         (re),
      .pc         (pc),
      .npc        (npc),
      .upd        (upd),
      .wb_valid   (wb_valid),
      .wb_is_cond (wb_is_cond),
      .wb_is_jump (wb_is_jump),
      .wb_taken   (wb_taken),
      .wb_pc      (wb_pc),
      .wb_target  (wb_target),
      .wb_upd     (wb_upd)
   );

   initial
   begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   task automatic apply_reset();
      @(negedge clk);
      rst_n    = 1'b0;
      re       = 1'b0;
      wb_valid = 1'b0;
      repeat (10) @(negedge clk);
      rst_n = 1'b1;
   endtask

   task automatic compare_slot(input int s, input word_t exp_npc, input logic [upd_w-1:0] exp_upd);
      n_checks++;
      if (npc[s] !== exp_npc)
      begin
         $display("Error: time %0t npc[%0d] expected %h actual %h", $time, s, exp_npc, npc[s]);
         n_errs++;
         test_errs++;
      end
      if (upd[s] !== upd_t'(exp_upd))
      begin
         $display("Error: time %0t upd[%0d] expected %h actual %h", $time, s, exp_upd, upd[s]);
         n_errs++;
         test_errs++;
      end
   endtask

   // A short line would leave stale fields from the previous command
   task automatic check_fields(input int got, input int want, input string text);
      if (got != want)
      begin
         $display("Malformed vector line, %0d of %0d fields read: %s", got, want, text);
         n_errs++;
         test_errs++;
      end
   endtask

   task automatic write_back(input logic cond, input logic jump, input logic taken,
                             input word_t bpc, input word_t tgt, input logic [upd_w-1:0] tok);
      @(negedge clk);
      re         = 1'b0;
      wb_valid   = 1'b1;
      wb_is_cond = cond;
      wb_is_jump = jump;
      wb_taken   = taken;
      wb_pc      = bpc;
      wb_target  = tgt;
      wb_upd     = upd_t'(tok);
      @(negedge clk);
      wb_valid = 1'b0;
   endtask

   initial
   begin
      int                fd;
      int                nf;
      int                n_resets;
      longint            budget;
      string             line;
      string             cmd;
      string             name;
      string             lines[$];
      word_t             a0, a1, n0, n1;
      logic [upd_w-1:0]  u0, u1;
      logic              f_cond, f_jump, f_taken;

      void'($urandom(56));
      n_checks   = 0;
      n_errs     = 0;
      n_tests    = 0;
      test_errs  = 0;
      n_resets   = 0;
      rst_n      = 1'b0;
      re         = 1'b0;
      pc         = '0;
      wb_valid   = 1'b0;
      wb_is_cond = 1'b0;
      wb_is_jump = 1'b0;
      wb_taken   = 1'b0;
      wb_pc      = '0;
      wb_target  = '0;
      wb_upd     = '0;

      fd = $fopen("tests/bpu_vectors.txt", "r");
      if (fd == 0)
      begin
         $display("Could not open the vector file tests/bpu_vectors.txt");
         n_errs++;
      end
      else
      begin
         while ($fgets(line, fd) > 0)
         begin
            if ($sscanf(line, "%s", cmd) == 1 && cmd.substr(0, 0) != "#")
            begin
               lines.push_back(line);
               if (cmd == "R")
                  n_resets++;
            end
         end
         $fclose(fd);
      end

      // Each command takes up to four cycles, each reset about twelve
      budget = (longint'(lines.size()) * 4 + longint'(n_resets) * 12 + 24) * clk_period;
      fork
         begin
            #(budget);
            $display("Watchdog expired, the run did not finish in time");
            $display("TEST RESULT: FAIL");
            $finish;
         end
      join_none

      apply_reset();
      foreach (lines[i])
      begin
         nf = $sscanf(lines[i], "%s", cmd);
         if (cmd == "R")
            apply_reset();
         else if (cmd == "L")
         begin
            nf = $sscanf(lines[i], "%s %h %h %h %h %h %h", cmd, a0, a1, n0, u0, n1, u1);
            check_fields(nf, 7, lines[i]);
            @(negedge clk);
            re    = 1'b1;
            pc[0] = a0;
            pc[1] = a1;
            @(negedge clk);
            re = 1'b0;
            compare_slot(0, n0, u0);
            compare_slot(1, n1, u1);
         end
         else if (cmd == "H")
         begin
            nf = $sscanf(lines[i], "%s %h %h %h %h", cmd, n0, u0, n1, u1);
            check_fields(nf, 5, lines[i]);
            @(negedge clk);
            re    = 1'b0;
            pc[0] = word_t'($urandom);
            pc[1] = word_t'($urandom);
            @(negedge clk);
            compare_slot(0, n0, u0);
            compare_slot(1, n1, u1);
         end
         else if (cmd == "W")
         begin
            nf = $sscanf(lines[i], "%s %h %h %h %h %h %h", cmd, f_cond, f_jump, f_taken,
                         a0, a1, u0);
            check_fields(nf, 7, lines[i]);
            write_back(f_cond, f_jump, f_taken, a0, a1, u0);
         end
         else if (cmd == "E")
         begin
            nf = $sscanf(lines[i], "%s %s", cmd, name);
            check_fields(nf, 2, lines[i]);
            n_tests++;
            $display("Test %s finished with %0d errors", name, test_errs);
            test_errs = 0;
         end
         else
         begin
            $display("Unknown command %s in the vector file", cmd);
            n_errs++;
         end
      end

      $display("Tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errs);
      if (n_errs == 0)
         $display("TEST RESULT: PASS");
      else
         $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// File: src.f
logic/bpu_pkg.sv
logic/bpu_table.sv
logic/bpu_pht.sv
logic/bpu_btb.sv
logic/bpu_npc_sel.sv
logic/bpu.sv
tests/bpu_chk.sv
tests/bpu_tb.sv

// File: Makefile
# Verilator build and run for the branch prediction unit testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := bpu_tb
FILELIST  := src.f
OBJ_DIR   := obj_dir
LOG       := sim.log
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -E '\.s?v$$' $(FILELIST))
VECTORS   := tests/bpu_vectors.txt

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN) $(VECTORS)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tests/bpu_vectors.txt
# R: reset | L pc0 pc1 npc0 upd0 npc1 upd1 | H npc0 upd0 npc1 upd1 (re low, random pc)
# W cond jump taken pc target upd | E test_name | values in hex, upd = {ctr, idx}
H 1 000 1 000
L 100 23 101 100 24 123
L 3fffffff 12345 0 1ff 12346 145
E after_reset
R
W 0 1 1 1000 2000 000
L 1000 1040 2000 100 1041 140
W 1 0 0 1000 0 000
L 1000 1040 2000 000 1041 140
E jump_redirect
R
W 1 0 1 505 700 004
L 505 800 506 104 801 101
W 1 0 1 505 700 106
L 505 800 700 206 801 103
W 1 0 1 505 700 202
L 505 800 700 302 801 107
W 1 0 1 505 700 30a
L 505 800 700 30a 801 10f
W 1 0 0 505 700 31b
L 505 800 700 21b 801 11e
W 1 0 0 505 700 239
L 505 800 506 139 801 13c
W 1 0 0 505 700 17d
L 505 800 506 07d 801 178
W 1 0 0 505 700 0f5
L 505 800 506 0f5 801 1f0
E counter_training
R
W 1 0 1 20 30 0aa
W 1 0 0 21 0 1bb
W 1 0 1 22 40 0cc
L 1234 ab 1235 131 ac 1ae
L 20 1be 21 125 1bf 0bb
W 0 1 1 2000 10 000
L 2000 ab 10 105 ac 1ae
E history
H 10 105 ac 1ae
H 10 105 ac 1ae
E hold
R
W 0 1 1 111 aaa 000
W 0 1 1 222 bbb 000
L 111 222 aaa 111 bbb 122
L 222 111 bbb 122 aaa 111
E dual_slot
